// File: hdl/conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// pixel words per image line, 3 or more
`define LINE_PAIRS 8

// column counter width, must hold LINE_PAIRS-1
`define LINE_ADDR_W 3

// one lane pixel
`define PIX_W 8

// 3x3 kernel
`define TAPS 9

// lowest lane sum bit kept at the output
`define CONV_SHIFT 7

`endif

// File: hdl/conv_pixel_pkg.sv
`default_nettype none

`include "conv_settings.svh"

package conv_pixel_pkg;

    // one unsigned lane pixel
    typedef logic [`PIX_W-1:0] pix_t;

    // two image planes side by side in one word
    typedef struct packed {
        pix_t hi;
        pix_t lo;
    } pix_pair_t;

    // three rows of one image column, top is the oldest row
    typedef struct packed {
        pix_pair_t top;
        pix_pair_t mid;
        pix_pair_t bot;
        logic      first_col;
        logic      rows_ready;
    } column_t;

    // [column][row], column 0 oldest, row 0 top
    typedef pix_pair_t [2:0][2:0] window_t;

    typedef enum logic [1:0] {
        fill_empty,
        fill_one,
        fill_two,
        fill_full
    } fill_state_t;

endpackage

`default_nettype wire

// File: hdl/conv_kernel_pkg.sv
`default_nettype none

package conv_kernel_pkg;

    // signed kernel tap
    typedef logic signed [7:0] coef_t;

    // row-major, top-left is tap 0
    typedef logic [3:0] tap_idx_t;

    typedef struct packed {
        logic     en;
        tap_idx_t addr;
        coef_t    data;
    } kernel_wr_t;

    // nine 17-bit products fit in 20 bits
    typedef logic signed [19:0] lane_sum_t;

endpackage

`default_nettype wire

// File: hdl/row_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module row_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pix_valid,
    input  conv_pixel_pkg::pix_pair_t pix_in,
    output logic                      col_valid,
    output conv_pixel_pkg::column_t   col
);

    // line 0 is the previous line, line 1 the one before it
    conv_pixel_pkg::pix_pair_t line0 [`LINE_PAIRS];
    conv_pixel_pkg::pix_pair_t line1 [`LINE_PAIRS];

    logic [`LINE_ADDR_W-1:0] col_cnt;
    logic [1:0]              row_cnt;
    logic                    last_col;

    assign last_col = (int'(col_cnt) == `LINE_PAIRS - 1);

    ////////////////////////////////////////////////////////////
    // column and row counters

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (pix_valid) begin
            if (last_col) begin
                col_cnt <= '0;
                // saturate once two full lines are stored
                if (row_cnt != 2'd2) begin
                    row_cnt <= row_cnt + 2'd1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // line cascade and column output

    always_ff @(posedge clk) begin
        if (rst) begin
            col_valid <= 1'b0;
        end else begin
            col_valid <= pix_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            col.top        <= line1[col_cnt];
            col.mid        <= line0[col_cnt];
            col.bot        <= pix_in;
            col.first_col  <= (col_cnt == '0);
            col.rows_ready <= (row_cnt == 2'd2);
            // shift this column one line down the cascade
            line1[col_cnt] <= line0[col_cnt];
            line0[col_cnt] <= pix_in;
        end
    end

    a_col_cnt_range: assert property (
        @(posedge clk) disable iff (rst) int'(col_cnt) < `LINE_PAIRS
    ) else $error("row_buffer column counter left the line");

endmodule

`default_nettype wire

// File: hdl/window_regs.sv
`timescale 1ns/1ps
`default_nettype none

module window_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    col_valid,
    input  conv_pixel_pkg::column_t col,
    output logic                    win_valid,
    output conv_pixel_pkg::window_t win
);

    conv_pixel_pkg::window_t     slots;
    conv_pixel_pkg::fill_state_t fill_state;
    conv_pixel_pkg::fill_state_t fill_next;

    ////////////////////////////////////////////////////////////
    // fill state, restarts at each new line

    always_comb begin
        fill_next = fill_state;
        if (col_valid) begin
            if (col.first_col) begin
                fill_next = conv_pixel_pkg::fill_one;
            end else begin
                case (fill_state)
                    conv_pixel_pkg::fill_empty: fill_next = conv_pixel_pkg::fill_one;
                    conv_pixel_pkg::fill_one:   fill_next = conv_pixel_pkg::fill_two;
                    default:                    fill_next = conv_pixel_pkg::fill_full;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_state <= conv_pixel_pkg::fill_empty;
            win_valid  <= 1'b0;
        end else begin
            fill_state <= fill_next;
            // three columns held and all three rows real
            win_valid  <= col_valid && col.rows_ready &&
                          (fill_next == conv_pixel_pkg::fill_full);
        end
    end

    ////////////////////////////////////////////////////////////
    // column slots, 0 is the oldest

    always_ff @(posedge clk) begin
        if (col_valid) begin
            slots[0]    <= slots[1];
            slots[1]    <= slots[2];
            slots[2][0] <= col.top;
            slots[2][1] <= col.mid;
            slots[2][2] <= col.bot;
        end
    end

    assign win = slots;

    // no window may straddle two lines
    a_no_win_after_first: assert property (
        @(posedge clk) disable iff (rst)
        col_valid && col.first_col |-> ##2 !win_valid
    ) else $error("window_regs window built across a line start");

endmodule

`default_nettype wire

// File: hdl/conv_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module conv_mac (
    input  logic                        clk,
    input  logic                        rst,
    input  conv_kernel_pkg::kernel_wr_t kernel_wr,
    input  logic                        win_valid,
    input  conv_pixel_pkg::window_t     win,
    output logic                        out_valid,
    output conv_pixel_pkg::pix_pair_t   out_data
);

    // unsigned pixel times signed tap
    localparam int PROD_W = 2 * `PIX_W + 1;

    conv_kernel_pkg::coef_t taps [`TAPS];

    logic signed [PROD_W-1:0] prod_hi [`TAPS];
    logic signed [PROD_W-1:0] prod_lo [`TAPS];

    conv_kernel_pkg::lane_sum_t acc_hi;
    conv_kernel_pkg::lane_sum_t acc_lo;
    conv_kernel_pkg::lane_sum_t sum_hi;
    conv_kernel_pkg::lane_sum_t sum_lo;

    logic prod_valid;
    logic sum_valid;

    ////////////////////////////////////////////////////////////
    // kernel taps

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < `TAPS; t++) begin
                taps[t] <= '0;
            end
        end else if (kernel_wr.en) begin
            taps[kernel_wr.addr] <= kernel_wr.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 1, products per lane

    always_ff @(posedge clk) begin
        if (win_valid) begin
            for (int t = 0; t < `TAPS; t++) begin
                // tap t sits in row t/3, column t%3
                prod_hi[t] <= $signed({1'b0, win[t % 3][t / 3].hi}) * taps[t];
                prod_lo[t] <= $signed({1'b0, win[t % 3][t / 3].lo}) * taps[t];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 2, adder tree

    always_comb begin
        acc_hi = '0;
        acc_lo = '0;
        for (int t = 0; t < `TAPS; t++) begin
            acc_hi = acc_hi + prod_hi[t];
            acc_lo = acc_lo + prod_lo[t];
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            sum_hi <= acc_hi;
            sum_lo <= acc_lo;
        end
    end

    // stage 3, keep the selected byte of each lane sum
    always_ff @(posedge clk) begin
        if (sum_valid) begin
            out_data.hi <= sum_hi[`CONV_SHIFT +: `PIX_W];
            out_data.lo <= sum_lo[`CONV_SHIFT +: `PIX_W];
        end
    end

    // valid travels with the data
    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
            sum_valid  <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            prod_valid <= win_valid;
            sum_valid  <= prod_valid;
            out_valid  <= sum_valid;
        end
    end

    a_tap_addr: assert property (
        @(posedge clk) disable iff (rst)
        kernel_wr.en |-> int'(kernel_wr.addr) < `TAPS
    ) else $error("conv_mac kernel write beyond last tap");

endmodule

`default_nettype wire

// File: hdl/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pix_valid,
    input  conv_pixel_pkg::pix_pair_t   pix_in,
    input  conv_kernel_pkg::kernel_wr_t kernel_wr,
    output logic                        out_valid,
    output conv_pixel_pkg::pix_pair_t   out_data
);

    logic                    col_valid;
    conv_pixel_pkg::column_t col;
    logic                    win_valid;
    conv_pixel_pkg::window_t win;

    // raster pixels in, three-row columns out
    row_buffer u_row_buffer (
        .clk       (clk),
        .rst       (rst),
        .pix_valid (pix_valid),
        .pix_in    (pix_in),
        .col_valid (col_valid),
        .col       (col)
    );

    window_regs u_window_regs (
        .clk       (clk),
        .rst       (rst),
        .col_valid (col_valid),
        .col       (col),
        .win_valid (win_valid),
        .win       (win)
    );

    // both lanes, 3 cycles
    conv_mac u_conv_mac (
        .clk       (clk),
        .rst       (rst),
        .kernel_wr (kernel_wr),
        .win_valid (win_valid),
        .win       (win),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// File: testbench/tb_conv_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module tb_conv_top;

    localparam int NREC    = 256;
    localparam int TIMEOUT = 200;
    // outputs of test 3 whose windows reach into earlier lines
    localparam int SKIP    = 2 * (`LINE_PAIRS - 2);

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        pix_valid;
    conv_pixel_pkg::pix_pair_t   pix_in;
    conv_kernel_pkg::kernel_wr_t kernel_wr;
    logic                        out_valid;
    conv_pixel_pkg::pix_pair_t   out_data;

    logic [19:0]               recs [NREC];
    int                        marks [8];
    conv_pixel_pkg::pix_pair_t ref_top [`LINE_PAIRS];
    conv_pixel_pkg::pix_pair_t ref_mid [`LINE_PAIRS];
    conv_pixel_pkg::pix_pair_t ref_bot [`LINE_PAIRS];
    int                        ref_taps [`TAPS];
    int                        ref_col = 0;
    int                        ref_rows = 0;

    conv_pixel_pkg::pix_pair_t exp_data [$];
    int                        exp_cyc [$];
    conv_pixel_pkg::pix_pair_t first_run [$];

    int          cyc = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_num = 0;
    int          test_outs = 0;
    int          test_exp = 0;
    int          test_err = 0;
    bit          replaying = 1'b0;
    logic [31:0] lcg_state = 32'hccb7_0dfd;

    conv_top dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    ////////////////////////////////////////////////////////////
    // helpers

    task automatic check_value(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("Mismatch at %0t ns: %s got %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected lane byte for the window ending at column col
    function automatic logic [7:0] lane_result(input bit hi, input int col);
        logic signed [31:0]        sum;
        conv_pixel_pkg::pix_pair_t p;
        sum = '0;
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 3; k++) begin
                if (r == 0) begin
                    p = ref_top[col - 2 + k];
                end else if (r == 1) begin
                    p = ref_mid[col - 2 + k];
                end else begin
                    p = ref_bot[col - 2 + k];
                end
                sum = sum + (hi ? int'(p.hi) : int'(p.lo)) * ref_taps[3 * r + k];
            end
        end
        return sum[`CONV_SHIFT +: 8];
    endfunction

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data.size() > 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_data.size() > 0) begin
            $display("Timeout at %0t ns: expected output never arrived", $time);
            errors++;
            exp_data.delete();
            exp_cyc.delete();
        end
    endtask

    task automatic send_pixel(input conv_pixel_pkg::pix_pair_t p);
        conv_pixel_pkg::pix_pair_t e;
        pix_valid = 1'b1;
        pix_in    = p;
        ref_bot[ref_col] = p;
        if (ref_col >= 2 && ref_rows >= 2) begin
            e.hi = lane_result(1'b1, ref_col);
            e.lo = lane_result(1'b0, ref_col);
            exp_data.push_back(e);
            exp_cyc.push_back(cyc + 5);
            test_exp++;
        end
        // end of line, the model rows move down
        if (ref_col == `LINE_PAIRS - 1) begin
            ref_top = ref_mid;
            ref_mid = ref_bot;
            ref_col = 0;
            if (ref_rows < 2) begin
                ref_rows++;
            end
        end else begin
            ref_col++;
        end
        @(negedge clk);
        pix_valid = 1'b0;
    endtask

    task automatic write_tap(input conv_kernel_pkg::tap_idx_t addr,
                             input conv_kernel_pkg::coef_t data);
        wait_drain();
        kernel_wr.en   = 1'b1;
        kernel_wr.addr = addr;
        kernel_wr.data = data;
        ref_taps[addr] = int'(data);
        @(negedge clk);
        kernel_wr.en = 1'b0;
    endtask

    task automatic finish_test();
        wait_drain();
        if (test_num > 0) begin
            check_value("output count", test_outs, test_exp);
            $display("test %0d done: %0d outputs, %0d errors",
                     test_num, test_outs, errors - test_err);
        end
        replaying = 1'b0;
        test_outs = 0;
        test_exp  = 0;
        test_err  = errors;
    endtask

    task automatic replay_test(input int src);
        logic [19:0] rec;
        logic [31:0] r;
        replaying = 1'b1;
        for (int i = marks[src] + 1; i < marks[src + 1]; i++) begin
            rec = recs[i];
            if (rec[19:16] == 4'h1) begin
                write_tap(rec[11:8], rec[7:0]);
            end else if (rec[19:16] == 4'h2) begin
                send_pixel(rec[15:0]);
                r = next_random();
                idle_cycles(int'(r[30:29]));
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // output monitor

    always @(negedge clk) begin
        if (out_valid) begin
            if (exp_data.size() == 0) begin
                $display("Error at %0t ns: output appeared with no window pending", $time);
                errors++;
            end else begin
                check_value("lane hi", out_data.hi, exp_data[0].hi);
                check_value("lane lo", out_data.lo, exp_data[0].lo);
                check_value("latency in cycles", cyc, exp_cyc[0]);
                void'(exp_data.pop_front());
                void'(exp_cyc.pop_front());
            end
            if (test_num == 3 && !replaying) begin
                first_run.push_back(out_data);
            end
            if (replaying && test_outs >= SKIP && test_outs < first_run.size()) begin
                check_value("replay against test 3", out_data, first_run[test_outs]);
            end
            test_outs++;
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        logic [19:0] rec;
        bit          done;
        done      = 1'b0;
        rst       = 1'b1;
        pix_valid = 1'b0;
        pix_in    = '0;
        kernel_wr = '0;
        for (int t = 0; t < `TAPS; t++) begin
            ref_taps[t] = 0;
        end
        $readmemh("testbench/conv_testdata.hex", recs);
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check_value("out_valid in reset", out_valid, 0);
        end
        rst = 1'b0;
        for (int i = 0; i < NREC && !done; i++) begin
            rec = recs[i];
            case (rec[19:16])
                4'h1: write_tap(rec[11:8], rec[7:0]);
                4'h2: send_pixel(rec[15:0]);
                4'h3: idle_cycles(int'(rec[15:0]));
                4'h4: begin
                    finish_test();
                    test_num = int'(rec[15:0]);
                    marks[test_num] = i;
                end
                4'h5: begin
                    finish_test();
                    test_num++;
                    replay_test(int'(rec[15:0]));
                end
                default: begin
                    finish_test();
                    done = 1'b1;
                end
            endcase
        end
        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/conv_pixel_pkg.sv
hdl/conv_kernel_pkg.sv
hdl/row_buffer.sv
hdl/window_regs.sv
hdl/conv_mac.sv
hdl/conv_top.sv
testbench/tb_conv_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_conv_top
FILELIST  = verilog.f
BUILD     = obj_dir

SIM     = $(BUILD)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) hdl/conv_settings.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# pass only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD)

// File: testbench/conv_testdata.hex
// record = type digit + 16-bit payload: 1 = tap write (0 addr data), 2 = pixel (hi lo),
// 3 = idle cycles, 4 = start of test n, 5 = replay test n with random gaps, 0 = end
40001
10010 10110 10210 10310 10410 10510 10610 10710 10810
21204 23418 25a2c 27e40 29054 2b268 2d47c 2f690
20c0f 21e23 23037 2424b 2565f 27873 28a87 29c9b
// first two lines give no output
40002
2ffee 2eedd 2ddcc 30002 2ccbb 2bbaa 2aa99 30004 29988 28877
20110 20220 20330 20440 20550 20660 20770 20880
// mixed-sign kernel
40003
100f0 101e0 102f0 10308 10460 10508 10610 10720 10810
280ff 27fee 290dd 26fcc 2a0bb 25faa 2b099 24f88
21e01 22d12 23c23 24b34 25a45 26956 27867 28778
2f00f 2e01e 2d02d 2c03c 2b04b 2a05a 29069 28078
23355 244aa 25533 266cc 27722 288dd 29911 2aaee
// kernel rewritten between lines
40004
21111 22222 23333 24444 25555 26666 27777 28888
10020 101c0 10220 10300 1047f 10500 106e8 10740 108e8
2fe01 2dc23 2ba45 29867 27689 254ab 232cd 210ef
// test 3 again with random idle cycles
50003
00000
